// File: rob_pkg.sv
`default_nettype none

package rob_pkg;

    // machine sizes
    localparam int NUM_AREG  = 32;   // risc-v integer regs
    localparam int NUM_PREG  = 64;   // physical reg file
    localparam int ROB_DEPTH = 16;
    localparam int NUM_CMPL  = 3;    // fu completion ports
    localparam int RETIRE_W  = 2;    // commit slots per cycle

    localparam int XLEN      = 32;
    localparam int AREG_W    = $clog2(NUM_AREG);
    localparam int PREG_W    = $clog2(NUM_PREG);
    localparam int ROB_PTR_W = $clog2(ROB_DEPTH);

    typedef logic [AREG_W-1:0]    areg_t;
    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [ROB_PTR_W-1:0] rob_ptr_t;
    typedef logic [ROB_PTR_W:0]   rob_cnt_t;   // 0..ROB_DEPTH
    typedef logic [PREG_W-1:0]    fl_ptr_t;    // free list slot index
    typedef logic [PREG_W:0]      fl_cnt_t;    // 0..NUM_PREG
    typedef logic [XLEN-1:0]      word_t;
    typedef logic [XLEN-1:0]      pc_t;

    // from the front end, held while stalled
    typedef struct packed {
        logic  is_store;
        areg_t arch_rd;      // ignored for stores
        pc_t   pc;
        word_t store_addr;
        word_t store_data;
    } dispatch_t;

    // one per fu port, single cycle pulse
    typedef struct packed {
        logic  valid;
        pc_t   pc;           // matched against in-flight entries
        word_t data;
    } cmpl_t;

    // broadcast to issue / bypass
    typedef struct packed {
        logic  valid;
        preg_t preg;
        word_t data;
    } wakeup_t;

    // arf write or store release
    typedef struct packed {
        logic  valid;
        logic  is_store;
        areg_t arch_rd;
        word_t data;         // result, or store data
        word_t store_addr;
        pc_t   pc;
    } commit_t;

    typedef struct packed {
        logic  busy;
        logic  is_store;
        logic  complete;
        areg_t arch_rd;
        preg_t new_preg;
        preg_t old_preg;     // freed when this entry retires
        word_t data;
        word_t store_addr;
        word_t store_data;
        pc_t   pc;
    } rob_entry_t;

endpackage

`default_nettype wire

// File: rename_alloc.sv
`default_nettype none

module rename_alloc (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire                               dispatch_fire,
    input  wire rob_pkg::areg_t               arch_rd,
    input  wire                               is_store,
    input  wire [rob_pkg::RETIRE_W-1:0]       free_valid,
    input  wire rob_pkg::preg_t               free_preg [rob_pkg::RETIRE_W],
    output rob_pkg::preg_t                    new_preg,
    output rob_pkg::preg_t                    old_preg,
    output logic                              free_empty
);

    // speculative map, areg -> preg
    rob_pkg::preg_t  map_q [rob_pkg::NUM_AREG];

    // free list fifo, one slot per preg so it can never overflow
    rob_pkg::preg_t  fl_mem [rob_pkg::NUM_PREG];
    rob_pkg::fl_ptr_t fl_head_q;
    rob_pkg::fl_ptr_t fl_tail_q;
    rob_pkg::fl_cnt_t fl_count_q;

    logic             alloc;
    rob_pkg::fl_ptr_t push_ptr [rob_pkg::RETIRE_W];
    rob_pkg::fl_cnt_t push_n;

    assign alloc      = dispatch_fire && !is_store;   // stores take no preg
    assign new_preg   = fl_mem[fl_head_q];            // head of free list
    assign old_preg   = map_q[arch_rd];
    assign free_empty = (fl_count_q == '0);

    // pushes pack in slot order from the tail
    always_comb begin
        rob_pkg::fl_ptr_t ptr;
        ptr    = fl_tail_q;
        push_n = '0;
        for (int s = 0; s < rob_pkg::RETIRE_W; s++) begin
            push_ptr[s] = ptr;
            if (free_valid[s]) begin
                ptr    = ptr + 1'b1;
                push_n = push_n + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < rob_pkg::NUM_AREG; i++) begin
                map_q[i] <= rob_pkg::preg_t'(i);      // identity map
            end
            // slots 0..31 hold pregs 32..63, upper half is don't care
            for (int i = 0; i < rob_pkg::NUM_PREG; i++) begin
                fl_mem[i] <= rob_pkg::preg_t'(i + rob_pkg::NUM_AREG);
            end
            fl_head_q  <= '0;
            fl_tail_q  <= rob_pkg::fl_ptr_t'(rob_pkg::NUM_PREG - rob_pkg::NUM_AREG);
            fl_count_q <= rob_pkg::fl_cnt_t'(rob_pkg::NUM_PREG - rob_pkg::NUM_AREG);
        end else begin
            if (alloc) begin
                map_q[arch_rd] <= fl_mem[fl_head_q];
                fl_head_q      <= fl_head_q + 1'b1;
            end
            for (int s = 0; s < rob_pkg::RETIRE_W; s++) begin
                if (free_valid[s]) begin
                    fl_mem[push_ptr[s]] <= free_preg[s];
                end
            end
            fl_tail_q  <= fl_tail_q + rob_pkg::fl_ptr_t'(push_n);
            // up to two in, one out
            fl_count_q <= fl_count_q + push_n - rob_pkg::fl_cnt_t'(alloc);
        end
    end

endmodule

`default_nettype wire

// File: reorder_buffer.sv
`default_nettype none

module reorder_buffer (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire                               dispatch_fire,
    input  wire rob_pkg::dispatch_t           dispatch,
    input  wire rob_pkg::preg_t               new_preg,
    input  wire rob_pkg::preg_t               old_preg,
    input  wire rob_pkg::cmpl_t               cmpl [rob_pkg::NUM_CMPL],
    output logic                              rob_full,
    output rob_pkg::wakeup_t                  wakeup [rob_pkg::NUM_CMPL],
    output rob_pkg::commit_t                  commit [rob_pkg::RETIRE_W],
    output logic [rob_pkg::RETIRE_W-1:0]      free_valid,
    output rob_pkg::preg_t                    free_preg [rob_pkg::RETIRE_W]
);

    rob_pkg::rob_entry_t rob_q [rob_pkg::ROB_DEPTH];
    rob_pkg::rob_ptr_t   head_q;     // oldest entry
    rob_pkg::rob_ptr_t   tail_q;     // next free slot
    rob_pkg::rob_cnt_t   count_q;

    logic [rob_pkg::NUM_CMPL-1:0] hit;
    rob_pkg::rob_ptr_t            hit_idx [rob_pkg::NUM_CMPL];
    logic [rob_pkg::RETIRE_W-1:0] ret;
    rob_pkg::rob_ptr_t            ret_ptr [rob_pkg::RETIRE_W];
    rob_pkg::rob_cnt_t            ret_n;

    assign rob_full = (count_q == rob_pkg::rob_cnt_t'(rob_pkg::ROB_DEPTH));

    // cam on pc, in-flight pcs are unique so at most one hit per port
    always_comb begin
        for (int p = 0; p < rob_pkg::NUM_CMPL; p++) begin
            hit[p]     = 1'b0;
            hit_idx[p] = '0;
            for (int e = 0; e < rob_pkg::ROB_DEPTH; e++) begin
                if (cmpl[p].valid && rob_q[e].busy && !rob_q[e].complete &&
                    rob_q[e].pc == cmpl[p].pc) begin
                    hit[p]     = 1'b1;
                    hit_idx[p] = rob_pkg::rob_ptr_t'(e);
                end
            end
        end
    end

    // retire a complete prefix from the head, stop at the first hole
    always_comb begin
        logic chain;
        chain = 1'b1;
        ret_n = '0;
        for (int s = 0; s < rob_pkg::RETIRE_W; s++) begin
            ret_ptr[s] = head_q + rob_pkg::rob_ptr_t'(s);   // wraps at depth
            chain      = chain && rob_q[ret_ptr[s]].busy && rob_q[ret_ptr[s]].complete;
            ret[s]     = chain;
            ret_n      = ret_n + rob_pkg::rob_cnt_t'(chain);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                rob_q[i].busy     <= 1'b0;
                rob_q[i].complete <= 1'b0;
            end
            for (int p = 0; p < rob_pkg::NUM_CMPL; p++) begin
                wakeup[p].valid <= 1'b0;
            end
            for (int s = 0; s < rob_pkg::RETIRE_W; s++) begin
                commit[s].valid <= 1'b0;
            end
            free_valid <= '0;
        end else begin
            // retire, slots are registered pulses
            for (int s = 0; s < rob_pkg::RETIRE_W; s++) begin
                commit[s].valid      <= ret[s];
                commit[s].is_store   <= rob_q[ret_ptr[s]].is_store;
                commit[s].arch_rd    <= rob_q[ret_ptr[s]].arch_rd;
                commit[s].data       <= rob_q[ret_ptr[s]].is_store ?
                                        rob_q[ret_ptr[s]].store_data :
                                        rob_q[ret_ptr[s]].data;
                commit[s].store_addr <= rob_q[ret_ptr[s]].store_addr;
                commit[s].pc         <= rob_q[ret_ptr[s]].pc;
                // old mapping goes back to the free list
                free_valid[s]        <= ret[s] && !rob_q[ret_ptr[s]].is_store;
                free_preg[s]         <= rob_q[ret_ptr[s]].old_preg;
                if (ret[s]) begin
                    rob_q[ret_ptr[s]].busy     <= 1'b0;
                    rob_q[ret_ptr[s]].complete <= 1'b0;
                end
            end

            // completion, wakeup goes out the cycle after
            for (int p = 0; p < rob_pkg::NUM_CMPL; p++) begin
                if (hit[p]) begin
                    rob_q[hit_idx[p]].complete <= 1'b1;
                    rob_q[hit_idx[p]].data     <= cmpl[p].data;
                end
                wakeup[p].valid <= hit[p] && !rob_q[hit_idx[p]].is_store;   // no dest on sw
                wakeup[p].preg  <= rob_q[hit_idx[p]].new_preg;
                wakeup[p].data  <= cmpl[p].data;
            end

            // dispatch into the tail, slot is never a retiring one
            if (dispatch_fire) begin
                rob_q[tail_q].busy       <= 1'b1;
                rob_q[tail_q].is_store   <= dispatch.is_store;
                rob_q[tail_q].complete   <= 1'b0;
                rob_q[tail_q].arch_rd    <= dispatch.arch_rd;
                rob_q[tail_q].new_preg   <= new_preg;
                rob_q[tail_q].old_preg   <= old_preg;
                rob_q[tail_q].data       <= '0;
                rob_q[tail_q].store_addr <= dispatch.store_addr;
                rob_q[tail_q].store_data <= dispatch.store_data;
                rob_q[tail_q].pc         <= dispatch.pc;
                tail_q                   <= tail_q + 1'b1;
            end

            head_q  <= head_q + rob_pkg::rob_ptr_t'(ret_n);
            count_q <= count_q + rob_pkg::rob_cnt_t'(dispatch_fire) - ret_n;
        end
    end

endmodule

`default_nettype wire

// File: preg_ready_table.sv
`default_nettype none

module preg_ready_table (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire                               alloc_valid,
    input  wire rob_pkg::preg_t               alloc_preg,
    input  wire rob_pkg::wakeup_t             wakeup [rob_pkg::NUM_CMPL],
    output logic [rob_pkg::NUM_PREG-1:0]      issue_ready
);

    // one bit per preg, 1 = value available
    logic [rob_pkg::NUM_PREG-1:0] ready_q;

    assign issue_ready = ready_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ready_q <= '1;                          // committed state only
        end else begin
            if (alloc_valid) begin
                ready_q[alloc_preg] <= 1'b0;        // waiting on producer
            end
            // later assignment wins, so a wakeup beats the clear
            for (int p = 0; p < rob_pkg::NUM_CMPL; p++) begin
                if (wakeup[p].valid) begin
                    ready_q[wakeup[p].preg] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: ooo_commit_top.sv
`default_nettype none

module ooo_commit_top (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire                               dispatch_valid,
    input  wire rob_pkg::dispatch_t           dispatch,
    input  wire rob_pkg::cmpl_t               cmpl [rob_pkg::NUM_CMPL],
    output logic                              dispatch_stall,
    output rob_pkg::preg_t                    dispatch_preg,
    output rob_pkg::wakeup_t                  wakeup [rob_pkg::NUM_CMPL],
    output rob_pkg::commit_t                  commit [rob_pkg::RETIRE_W],
    output logic [rob_pkg::NUM_PREG-1:0]      issue_ready
);

    logic                         dispatch_fire;
    logic                         alloc_fire;    // dispatch that takes a preg
    logic                         rob_full;
    logic                         free_empty;
    rob_pkg::preg_t               new_preg;
    rob_pkg::preg_t               old_preg;
    logic [rob_pkg::RETIRE_W-1:0] free_valid;
    rob_pkg::preg_t               free_preg [rob_pkg::RETIRE_W];

    // stores need a rob slot but no preg
    assign dispatch_stall = rob_full || (free_empty && !dispatch.is_store);
    assign dispatch_fire  = dispatch_valid && !dispatch_stall;
    assign alloc_fire     = dispatch_fire && !dispatch.is_store;
    assign dispatch_preg  = new_preg;

    rename_alloc u_rename (
        .clk           (clk),
        .rstn          (rstn),
        .dispatch_fire (dispatch_fire),
        .arch_rd       (dispatch.arch_rd),
        .is_store      (dispatch.is_store),
        .free_valid    (free_valid),
        .free_preg     (free_preg),
        .new_preg      (new_preg),
        .old_preg      (old_preg),
        .free_empty    (free_empty)
    );

    reorder_buffer u_rob (
        .clk           (clk),
        .rstn          (rstn),
        .dispatch_fire (dispatch_fire),
        .dispatch      (dispatch),
        .new_preg      (new_preg),
        .old_preg      (old_preg),
        .cmpl          (cmpl),
        .rob_full      (rob_full),
        .wakeup        (wakeup),
        .commit        (commit),
        .free_valid    (free_valid),
        .free_preg     (free_preg)
    );

    preg_ready_table u_ready (
        .clk           (clk),
        .rstn          (rstn),
        .alloc_valid   (alloc_fire),
        .alloc_preg    (new_preg),
        .wakeup        (wakeup),
        .issue_ready   (issue_ready)
    );

endmodule

`default_nettype wire

// File: tb_ooo_commit_properties.sv
`default_nettype none

module tb_ooo_commit_properties (
    input wire                               clk,
    input wire                               rstn,
    input wire                               dispatch_stall,
    input wire rob_pkg::rob_cnt_t            rob_count,
    input wire rob_pkg::wakeup_t             wakeup [rob_pkg::NUM_CMPL],
    input wire rob_pkg::commit_t             commit [rob_pkg::RETIRE_W],
    input wire [rob_pkg::NUM_PREG-1:0]       issue_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    // retire fills slot 0 first
    a_slot_order: assert property (@(posedge clk) disable iff (!rstn)
        commit[1].valid |-> commit[0].valid)
        else $error("commit slot 1 valid while slot 0 is idle");

    a_full_stall: assert property (@(posedge clk) disable iff (!rstn)
        (rob_count == rob_pkg::rob_cnt_t'(rob_pkg::ROB_DEPTH)) |-> dispatch_stall)
        else $error("rob full but dispatch not stalled");

    // woken preg is ready one edge later
    for (genvar p = 0; p < rob_pkg::NUM_CMPL; p++) begin : g_wake
        a_wake_ready: assert property (@(posedge clk) disable iff (!rstn)
            wakeup[p].valid |=> issue_ready[$past(wakeup[p].preg)])
            else $error("woken preg still not ready on port %0d", p);
    end

endmodule

bind ooo_commit_top tb_ooo_commit_properties u_props (
    .clk            (clk),
    .rstn           (rstn),
    .dispatch_stall (dispatch_stall),
    .rob_count      (u_rob.count_q),      // occupancy lives inside the rob
    .wakeup         (wakeup),
    .commit         (commit),
    .issue_ready    (issue_ready)
);

`default_nettype wire

// File: tb_ooo_commit.sv
`default_nettype none

module tb_ooo_commit;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          MAX_CYCLES = 2000;   // whole run is a few hundred cycles
    localparam logic [31:0] SEED       = 32'h81a0_1f7a;

    // one in-flight instruction as the model sees it
    typedef struct packed {
        logic           st;
        rob_pkg::areg_t rd;
        rob_pkg::preg_t newp;
        rob_pkg::preg_t oldp;
        rob_pkg::word_t addr;
        rob_pkg::word_t sd;
        rob_pkg::word_t data;
    } model_t;

    logic                         clk = 1'b0;
    logic                         rstn;
    logic                         dispatch_valid;
    rob_pkg::dispatch_t           dispatch;
    rob_pkg::cmpl_t               cmpl [rob_pkg::NUM_CMPL];
    logic                         dispatch_stall;
    rob_pkg::preg_t               dispatch_preg;
    rob_pkg::wakeup_t             wakeup [rob_pkg::NUM_CMPL];
    rob_pkg::commit_t             commit [rob_pkg::RETIRE_W];
    logic [rob_pkg::NUM_PREG-1:0] issue_ready;

    rob_pkg::preg_t map_m [rob_pkg::NUM_AREG];
    rob_pkg::preg_t fl_q [$];               // model free list, head first
    rob_pkg::pc_t   order_q [$];            // program order
    model_t         inflight [rob_pkg::pc_t];

    int errors      = 0;
    int commits     = 0;
    int pair_cycles = 0;
    int cycles      = 0;

    ooo_commit_top dut (
        .clk            (clk),
        .rstn           (rstn),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .cmpl           (cmpl),
        .dispatch_stall (dispatch_stall),
        .dispatch_preg  (dispatch_preg),
        .wakeup         (wakeup),
        .commit         (commit),
        .issue_ready    (issue_ready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one retire slot against the oldest model entry
    task automatic check_commit(input int s);
        rob_pkg::pc_t pc;
        model_t       m;
        if (order_q.size() == 0) begin
            errors++;
            $display("commit slot %0d fired at %0t with nothing in flight", s, $time);
        end else begin
            pc = order_q.pop_front();
            m  = inflight[pc];
            inflight.delete(pc);
            commits++;
            check_eq("commit.pc", 64'(commit[s].pc), 64'(pc));
            check_eq("commit.is_store", 64'(commit[s].is_store), 64'(m.st));
            if (m.st) begin
                check_eq("commit.data", 64'(commit[s].data), 64'(m.sd));
                check_eq("commit.store_addr", 64'(commit[s].store_addr), 64'(m.addr));
            end else begin
                check_eq("commit.arch_rd", 64'(commit[s].arch_rd), 64'(m.rd));
                check_eq("commit.data", 64'(commit[s].data), 64'(m.data));
                fl_q.push_back(m.oldp);     // old mapping recycled in slot order
            end
        end
    endtask

    always @(negedge clk) begin
        if (rstn) begin
            for (int s = 0; s < rob_pkg::RETIRE_W; s++) begin
                if (commit[s].valid) check_commit(s);
            end
            if (commit[0].valid && commit[1].valid) pair_cycles++;
        end
    end

    task automatic do_dispatch(input logic st, input rob_pkg::areg_t rd, input rob_pkg::pc_t pc,
                               input rob_pkg::word_t addr, input rob_pkg::word_t sd);
        model_t m;
        dispatch_valid      = 1'b1;
        dispatch.is_store   = st;
        dispatch.arch_rd    = rd;
        dispatch.pc         = pc;
        dispatch.store_addr = addr;
        dispatch.store_data = sd;
        #1;                                 // let the stall settle
        check_eq("dispatch_stall", 64'(dispatch_stall), 64'(0));
        m = '{st: st, rd: rd, addr: addr, sd: sd, default: '0};
        if (!st) begin
            check_eq("dispatch_preg", 64'(dispatch_preg), 64'(fl_q[0]));
            m.oldp    = map_m[rd];
            m.newp    = fl_q.pop_front();
            map_m[rd] = m.newp;
        end
        inflight[pc] = m;
        order_q.push_back(pc);
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    // unknown pc or store gives no wakeup
    task automatic do_complete(input int port, input rob_pkg::pc_t pc);
        rob_pkg::word_t d;
        model_t         m;
        logic           wake;
        d    = $urandom;
        wake = 1'b0;
        m    = '0;
        if (inflight.exists(pc)) begin
            m            = inflight[pc];
            wake         = !m.st;
            m.data       = d;
            inflight[pc] = m;
        end
        cmpl[port].valid = 1'b1;
        cmpl[port].pc    = pc;
        cmpl[port].data  = d;
        @(negedge clk);
        cmpl[port].valid = 1'b0;
        check_eq("wakeup.valid", 64'(wakeup[port].valid), 64'(wake));
        if (wake) begin
            check_eq("wakeup.preg", 64'(wakeup[port].preg), 64'(m.newp));
            check_eq("wakeup.data", 64'(wakeup[port].data), 64'(d));
        end
    endtask

    task automatic drain();
        while (order_q.size() != 0) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic test_reset();
        for (int p = 0; p < rob_pkg::NUM_CMPL; p++) begin
            check_eq("wakeup.valid", 64'(wakeup[p].valid), 64'(0));
        end
        for (int s = 0; s < rob_pkg::RETIRE_W; s++) begin
            check_eq("commit.valid", 64'(commit[s].valid), 64'(0));
        end
        check_eq("issue_ready", 64'(issue_ready), {64{1'b1}});
        check_eq("dispatch_stall", 64'(dispatch_stall), 64'(0));
        check_eq("dispatch_preg", 64'(dispatch_preg), 64'(32));   // first free preg
        do_dispatch(1'b0, 5'd1, 32'h100, 32'h0, 32'h0);
        do_complete(0, 32'h100);
        drain();
    endtask

    task automatic test_rename();
        rob_pkg::preg_t p;
        p = fl_q[0];
        do_dispatch(1'b0, 5'd5, 32'h200, 32'h0, 32'h0);
        check_eq("issue_ready[p]", 64'(issue_ready[p]), 64'(0));
        do_complete(1, 32'h200);
        check_eq("issue_ready[p]", 64'(issue_ready[p]), 64'(0));  // set lands next edge
        @(negedge clk);
        check_eq("issue_ready[p]", 64'(issue_ready[p]), 64'(1));
        check_eq("wakeup.valid", 64'(wakeup[1].valid), 64'(0));   // single cycle pulse
        drain();
    endtask

    task automatic test_order();
        int pairs0;
        for (int i = 0; i < 5; i++) begin
            do_dispatch(1'b0, rob_pkg::areg_t'(10 + i), rob_pkg::pc_t'(32'h300 + 4 * i),
                        32'h0, 32'h0);
        end
        pairs0 = pair_cycles;
        // head completes last, so the whole run retires 2, 2, 1
        for (int i = 4; i >= 0; i--) do_complete(i % 3, rob_pkg::pc_t'(32'h300 + 4 * i));
        drain();
        check_eq("pair_cycles", 64'(pair_cycles - pairs0), 64'(2));
    endtask

    task automatic test_store();
        rob_pkg::preg_t head;
        head = fl_q[0];
        do_dispatch(1'b1, 5'd0, 32'h400, 32'h8000_0040, 32'hdead_beef);
        check_eq("dispatch_preg", 64'(dispatch_preg), 64'(head));  // no preg taken
        do_complete(2, 32'h404);            // stray pc, ignored
        @(negedge clk);
        check_eq("commit.valid", 64'(commit[0].valid), 64'(0));  // store still incomplete
        do_complete(2, 32'h400);
        drain();
    endtask

    task automatic test_full();
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            do_dispatch(1'b0, rob_pkg::areg_t'(i + 1), rob_pkg::pc_t'(32'h500 + 4 * i),
                        32'h0, 32'h0);
        end
        dispatch_valid   = 1'b1;            // held against the stall
        dispatch.arch_rd = 5'd7;
        dispatch.pc      = 32'h5ff0;
        repeat (3) begin
            #1;
            check_eq("dispatch_stall", 64'(dispatch_stall), 64'(1));
            check_eq("dispatch_preg", 64'(dispatch_preg), 64'(fl_q[0]));
            @(negedge clk);
        end
        dispatch_valid = 1'b0;
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            do_complete(i % 3, rob_pkg::pc_t'(32'h500 + 4 * i));
        end
        drain();
        check_eq("dispatch_stall", 64'(dispatch_stall), 64'(0));
        // runs past the last initial pregs into recycled ones
        for (int i = 0; i < 12; i++) begin
            do_dispatch(1'b0, rob_pkg::areg_t'(i + 20), rob_pkg::pc_t'(32'h600 + 4 * i),
                        32'h0, 32'h0);
        end
        for (int i = 0; i < 12; i++) do_complete(i % 3, rob_pkg::pc_t'(32'h600 + 4 * i));
        drain();
    endtask

    initial begin
        void'($urandom(SEED));
        rstn           = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        for (int p = 0; p < rob_pkg::NUM_CMPL; p++) cmpl[p] = '0;
        for (int i = 0; i < rob_pkg::NUM_AREG; i++) map_m[i] = rob_pkg::preg_t'(i);
        for (int i = rob_pkg::NUM_AREG; i < rob_pkg::NUM_PREG; i++) begin
            fl_q.push_back(rob_pkg::preg_t'(i));
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        test_reset();
        test_rename();
        test_order();
        test_store();
        test_full();
        $display("errors %0d, commits %0d, paired cycles %0d", errors, commits, pair_cycles);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
rob_pkg.sv
rename_alloc.sv
reorder_buffer.sv
preg_ready_table.sv
ooo_commit_top.sv
tb_ooo_commit_properties.sv
tb_ooo_commit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_ooo_commit -f all.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
